/* fifo_pkg.sv */
package fifo_pkg;

   // ########################################
   // fifo geometry
   // ########################################
   localparam int FIFO_WIDTH      = 32;                  // data word width
   localparam int FIFO_DEPTH      = 16;                  // entries, power of two
   localparam int ADDR_WIDTH      = $clog2(FIFO_DEPTH);  // memory address bits
   localparam int PTR_WIDTH       = ADDR_WIDTH + 1;      // extra wrap bit

   // ########################################
   // clock crossing and flags
   // ########################################
   localparam int SYNC_STAGES     = 2;                   // flops per synchronizer
   localparam int PROG_FULL_LEVEL = 12;                  // wr_prog_full threshold

   // binary to gray, one bit flips per increment
   function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   // gray back to binary, msb down
   function automatic logic [PTR_WIDTH-1:0] gray2bin(input logic [PTR_WIDTH-1:0] gray);
      logic [PTR_WIDTH-1:0] bin;
      bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];             // msb passes through
      for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];                   // running xor
      end
      return bin;
   endfunction

endpackage

/* fifo_rsync.sv */
`timescale 1ns/1ps

module fifo_rsync (
   input  logic clk,          // domain clock
   input  logic nreset_in,    // async reset, active low
   output logic nreset_out    // reset with clean release
);
   import fifo_pkg::*;

   logic [SYNC_STAGES-1:0] sync_q;   // shift chain, fills with ones

   // assert at once, release after SYNC_STAGES edges
   always_ff @(posedge clk or negedge nreset_in) begin
      if (!nreset_in) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign nreset_out = sync_q[SYNC_STAGES-1];   // last stage drives domain

   // domain must stay in reset as long as the source reset is held
   a_reset_held: assert property (@(posedge clk) !nreset_in |-> !nreset_out)
      else $error("fifo_rsync: nreset_out released while nreset_in low");

endmodule

/* fifo_wr_ptr.sv */
`timescale 1ns/1ps

module fifo_wr_ptr (
   input  logic                            wr_clk,
   input  logic                            wr_rst_n,
   input  logic                            wr_accept,       // write taken this cycle
   input  logic [fifo_pkg::PTR_WIDTH-1:0]  rd_gray,         // from read domain
   output logic [fifo_pkg::ADDR_WIDTH-1:0] wr_addr,         // memory write address
   output logic [fifo_pkg::PTR_WIDTH-1:0]  wr_gray,         // to read domain
   output logic                            wr_full,
   output logic                            wr_almost_full,  // one slot left
   output logic                            wr_prog_full,
   output logic [fifo_pkg::PTR_WIDTH-1:0]  wr_count         // never under the true fill
);
   import fifo_pkg::*;

   logic [PTR_WIDTH-1:0]                  wr_bin;           // binary write pointer
   logic [PTR_WIDTH-1:0]                  wr_bin_next;
   logic [SYNC_STAGES-1:0][PTR_WIDTH-1:0] rd_gray_sync;     // read pointer chain
   logic [PTR_WIDTH-1:0]                  rd_bin_sync;      // lagging read pointer

   // ########################################
   // write pointer
   // ########################################
   assign wr_bin_next = wr_bin + PTR_WIDTH'(wr_accept);

   always_ff @(posedge wr_clk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= bin2gray(wr_bin_next);   // registered, glitch free crossing
      end
   end

   assign wr_addr = wr_bin[ADDR_WIDTH-1:0];   // drop wrap bit

   // ########################################
   // read pointer into wr_clk
   // ########################################
   always_ff @(posedge wr_clk or negedge wr_rst_n) begin
      if (!wr_rst_n) begin
         rd_gray_sync <= '0;
      end else begin
         rd_gray_sync <= {rd_gray_sync[SYNC_STAGES-2:0], rd_gray};
      end
   end

   assign rd_bin_sync = gray2bin(rd_gray_sync[SYNC_STAGES-1]);

   // ########################################
   // fill level and flags
   // ########################################
   // stale read pointer only overstates the fill
   assign wr_count       = wr_bin - rd_bin_sync;
   assign wr_full        = (wr_count == PTR_WIDTH'(FIFO_DEPTH));
   assign wr_almost_full = (wr_count >= PTR_WIDTH'(FIFO_DEPTH - 1));
   assign wr_prog_full   = (wr_count >= PTR_WIDTH'(PROG_FULL_LEVEL));

   // gray pointer seen by the read domain moves one bit at a time
   a_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      $countones(wr_gray ^ $past(wr_gray)) <= 1)
      else $error("fifo_wr_ptr: wr_gray changed by more than one bit");

   // top gating must never let a write through on full
   a_no_overflow: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
      wr_accept |-> !wr_full)
      else $error("fifo_wr_ptr: write accepted while full");

endmodule

/* fifo_rd_ptr.sv */
`timescale 1ns/1ps

module fifo_rd_ptr (
   input  logic                            rd_clk,
   input  logic                            rd_rst_n,
   input  logic                            rd_accept,   // read taken this cycle
   input  logic [fifo_pkg::PTR_WIDTH-1:0]  wr_gray,     // from write domain
   output logic [fifo_pkg::ADDR_WIDTH-1:0] rd_addr,     // memory read address
   output logic [fifo_pkg::PTR_WIDTH-1:0]  rd_gray,     // to write domain
   output logic                            rd_empty,
   output logic [fifo_pkg::PTR_WIDTH-1:0]  rd_count     // never over the readable count
);
   import fifo_pkg::*;

   logic [PTR_WIDTH-1:0]                  rd_bin;        // binary read pointer
   logic [PTR_WIDTH-1:0]                  rd_bin_next;
   logic [SYNC_STAGES-1:0][PTR_WIDTH-1:0] wr_gray_sync;  // write pointer chain
   logic [PTR_WIDTH-1:0]                  wr_bin_sync;

   // ########################################
   // read pointer
   // ########################################
   assign rd_bin_next = rd_bin + PTR_WIDTH'(rd_accept);

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= bin2gray(rd_bin_next);
      end
   end

   assign rd_addr = rd_bin[ADDR_WIDTH-1:0];

   // ########################################
   // write pointer into rd_clk
   // ########################################
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wr_gray_sync <= '0;
      end else begin
         wr_gray_sync <= {wr_gray_sync[SYNC_STAGES-2:0], wr_gray};
      end
   end

   assign wr_bin_sync = gray2bin(wr_gray_sync[SYNC_STAGES-1]);

   // empty straight from gray compare, no decode needed
   assign rd_empty = (rd_gray == wr_gray_sync[SYNC_STAGES-1]);
   assign rd_count = wr_bin_sync - rd_bin;   // lagging writer, understates

   // read gating at the top must respect empty
   a_no_underflow: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
      rd_accept |-> !rd_empty)
      else $error("fifo_rd_ptr: read accepted while empty");

endmodule

/* fifo_dpram.sv */
`timescale 1ns/1ps

module fifo_dpram (
   // write port
   input  logic                             wr_clk,
   input  logic                             wr_accept,
   input  logic [fifo_pkg::ADDR_WIDTH-1:0]  wr_addr,
   input  logic [fifo_pkg::FIFO_WIDTH-1:0]  wr_din,
   // read port
   input  logic                             rd_clk,
   input  logic                             rd_rst_n,
   input  logic                             rd_accept,
   input  logic [fifo_pkg::ADDR_WIDTH-1:0]  rd_addr,
   output logic [fifo_pkg::FIFO_WIDTH-1:0]  rd_dout     // valid the cycle after accept
);
   import fifo_pkg::*;

   logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];   // storage array

   // ########################################
   // write side
   // ########################################
   always_ff @(posedge wr_clk) begin
      if (wr_accept) begin
         mem[wr_addr] <= wr_din;
      end
   end

   // ########################################
   // read side, output register
   // ########################################
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         rd_dout <= '0;
      end else if (rd_accept) begin
         rd_dout <= mem[rd_addr];   // holds until next accepted read
      end
   end

endmodule

/* fifo_async.sv */
`timescale 1ns/1ps

module fifo_async (
   input  logic                            rd_clk,
   input  logic                            rd_nreset,       // async, active low, both domains
   input  logic                            wr_clk,
   // write port
   input  logic                            wr_en,
   input  logic [fifo_pkg::FIFO_WIDTH-1:0] wr_din,
   output logic                            wr_full,
   output logic                            wr_almost_full,
   output logic                            wr_prog_full,
   output logic [fifo_pkg::PTR_WIDTH-1:0]  wr_count,
   // read port
   input  logic                            rd_en,
   output logic [fifo_pkg::FIFO_WIDTH-1:0] rd_dout,
   output logic                            rd_empty,
   output logic [fifo_pkg::PTR_WIDTH-1:0]  rd_count
);
   import fifo_pkg::*;

   logic                  wr_rst_n;     // wr_clk domain reset
   logic                  rd_rst_n;     // rd_clk domain reset
   logic                  wr_accept;
   logic                  rd_accept;
   logic [ADDR_WIDTH-1:0] wr_addr;
   logic [ADDR_WIDTH-1:0] rd_addr;
   logic [PTR_WIDTH-1:0]  wr_gray;      // crosses to rd_clk
   logic [PTR_WIDTH-1:0]  rd_gray;      // crosses to wr_clk

   // ########################################
   // resets
   // ########################################
   fifo_rsync i_wr_rsync (
      .clk        (wr_clk),
      .nreset_in  (rd_nreset),
      .nreset_out (wr_rst_n)
   );

   fifo_rsync i_rd_rsync (
      .clk        (rd_clk),
      .nreset_in  (rd_nreset),
      .nreset_out (rd_rst_n)
   );

   // ########################################
   // handshake gating
   // ########################################
   assign wr_accept = wr_en & ~wr_full;    // writes on full dropped
   assign rd_accept = rd_en & ~rd_empty;   // reads on empty ignored

   fifo_wr_ptr i_wr_ptr (
      .wr_clk         (wr_clk),
      .wr_rst_n       (wr_rst_n),
      .wr_accept      (wr_accept),
      .rd_gray        (rd_gray),
      .wr_addr        (wr_addr),
      .wr_gray        (wr_gray),
      .wr_full        (wr_full),
      .wr_almost_full (wr_almost_full),
      .wr_prog_full   (wr_prog_full),
      .wr_count       (wr_count)
   );

   fifo_rd_ptr i_rd_ptr (
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .rd_accept (rd_accept),
      .wr_gray   (wr_gray),
      .rd_addr   (rd_addr),
      .rd_gray   (rd_gray),
      .rd_empty  (rd_empty),
      .rd_count  (rd_count)
   );

   // ########################################
   // storage
   // ########################################
   fifo_dpram i_dpram (
      .wr_clk    (wr_clk),
      .wr_accept (wr_accept),
      .wr_addr   (wr_addr),
      .wr_din    (wr_din),
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .rd_accept (rd_accept),
      .rd_addr   (rd_addr),
      .rd_dout   (rd_dout)
   );

endmodule

/* tb_fifo_async.sv */
`timescale 1ns/1ps

module tb_fifo_async;
   import fifo_pkg::*;

   localparam int LAG_ALLOW = SYNC_STAGES + 3;   // reads the wr side cannot see yet
   localparam int TIMEOUT   = 400;               // cycles allowed per wait loop

   logic                  rd_clk;
   logic                  wr_clk;
   logic                  rd_nreset;
   logic                  wr_en;
   logic [FIFO_WIDTH-1:0] wr_din;
   logic                  wr_full;
   logic                  wr_almost_full;
   logic                  wr_prog_full;
   logic [PTR_WIDTH-1:0]  wr_count;
   logic                  rd_en;
   logic [FIFO_WIDTH-1:0] rd_dout;
   logic                  rd_empty;
   logic [PTR_WIDTH-1:0]  rd_count;

   logic [FIFO_WIDTH-1:0] model_q[$];     // reference contents, oldest first
   logic [FIFO_WIDTH-1:0] expect_dout;    // word popped on the last accepted read
   logic                  expect_valid;
   int                    wr_pct;         // write enable chance in percent
   int                    rd_pct;
   int                    value_errors;
   int                    other_errors;
   int                    seg;

   fifo_async i_dut (
      .rd_clk         (rd_clk),
      .rd_nreset      (rd_nreset),
      .wr_clk         (wr_clk),
      .wr_en          (wr_en),
      .wr_din         (wr_din),
      .wr_full        (wr_full),
      .wr_almost_full (wr_almost_full),
      .wr_prog_full   (wr_prog_full),
      .wr_count       (wr_count),
      .rd_en          (rd_en),
      .rd_dout        (rd_dout),
      .rd_empty       (rd_empty),
      .rd_count       (rd_count)
   );

   always #4 rd_clk = ~rd_clk;     // 8 ns
   always #5.5 wr_clk = ~wr_clk;   // 11 ns, rising edges never meet rd_clk rising edges

   // ########################################
   // helpers
   // ########################################
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
         value_errors++;
      end
   endtask

   task automatic report_problem(input string what);
      $display("error at %0t: %s", $time, what);
      other_errors++;
   endtask

   task automatic wait_wr_full();
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge wr_clk);
         if (wr_full) break;
      end
      if (!wr_full) report_problem("timed out waiting for wr_full");
   endtask

   task automatic wait_rd_empty();
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(negedge rd_clk);
         if (rd_empty) break;
      end
      if (!rd_empty) report_problem("timed out waiting for rd_empty");
   endtask

   // ########################################
   // drivers, 1 ns after own edge
   // ########################################
   always @(posedge wr_clk) begin
      #1;
      wr_en  = ($urandom % 100) < wr_pct;
      wr_din = $urandom;
   end

   always @(posedge rd_clk) begin
      #1;
      rd_en = ($urandom % 100) < rd_pct;
   end

   // ########################################
   // model and monitors
   // ########################################
   always @(posedge wr_clk) begin
      if (rd_nreset) begin
         if (!wr_full && model_q.size() >= FIFO_DEPTH) report_problem("wr_full low on a full FIFO");
         if (32'(wr_count) < model_q.size()) report_problem("wr_count below stored words");
         if (wr_prog_full && model_q.size() < PROG_FULL_LEVEL - LAG_ALLOW) begin
            report_problem("wr_prog_full high far below its level");
         end
         if (wr_en && !wr_full) model_q.push_back(wr_din);   // accepted at the ports
      end
   end

   always @(posedge rd_clk) begin
      if (!rd_nreset) begin
         expect_valid = 1'b0;
      end else begin
         if (expect_valid) check_value("rd_dout", rd_dout, expect_dout);
         expect_valid = 1'b0;
         if (!rd_empty && model_q.size() == 0) report_problem("rd_empty low on an empty FIFO");
         if (32'(rd_count) > model_q.size()) report_problem("rd_count above readable words");
         if (rd_en && !rd_empty) begin
            if (model_q.size() == 0) begin
               report_problem("read accepted with nothing in the model");
            end else begin
               expect_dout  = model_q.pop_front();
               expect_valid = 1'b1;   // data due one rd_clk later
            end
         end
      end
   end

   // ########################################
   // test sequence
   // ########################################
   initial begin
      void'($urandom(32'h80ed));
      rd_clk       = 1'b0;
      wr_clk       = 1'b0;
      rd_nreset    = 1'b0;
      wr_en        = 1'b0;
      wr_din       = '0;
      rd_en        = 1'b0;
      wr_pct       = 0;
      rd_pct       = 0;
      expect_valid = 1'b0;
      expect_dout  = '0;
      value_errors = 0;
      other_errors = 0;

      repeat (10) @(posedge rd_clk);
      #1 rd_nreset = 1'b1;
      repeat (SYNC_STAGES + 2) @(posedge wr_clk);
      repeat (SYNC_STAGES + 2) @(posedge rd_clk);
      @(negedge rd_clk);
      check_value("rd_empty", 32'(rd_empty), 32'h1);
      check_value("wr_full", 32'(wr_full), 32'h0);
      check_value("wr_almost_full", 32'(wr_almost_full), 32'h0);
      check_value("wr_prog_full", 32'(wr_prog_full), 32'h0);
      check_value("wr_count", 32'(wr_count), 32'h0);
      check_value("rd_count", 32'(rd_count), 32'h0);
      check_value("rd_dout", rd_dout, 32'h0);

      // mixed traffic, order checked by the monitor
      wr_pct = 70;
      rd_pct = 60;
      repeat (600) @(posedge rd_clk);

      // quiet both sides so the read pointer settles, then fill
      wr_pct = 0;
      rd_pct = 0;
      repeat (SYNC_STAGES + 3) @(posedge rd_clk);
      repeat (SYNC_STAGES + 3) @(posedge wr_clk);
      wr_pct = 100;
      wait_wr_full();
      check_value("model size", 32'(model_q.size()), 32'(FIFO_DEPTH));
      check_value("wr_count", 32'(wr_count), 32'(FIFO_DEPTH));
      check_value("wr_almost_full", 32'(wr_almost_full), 32'h1);
      check_value("wr_prog_full", 32'(wr_prog_full), 32'h1);
      repeat (10) @(negedge wr_clk);   // writes on full go nowhere
      check_value("model size", 32'(model_q.size()), 32'(FIFO_DEPTH));

      // drain
      wr_pct = 0;
      rd_pct = 100;
      wait_rd_empty();
      repeat (SYNC_STAGES + 3) @(negedge rd_clk);
      check_value("model size", 32'(model_q.size()), 32'h0);
      check_value("rd_count", 32'(rd_count), 32'h0);
      repeat (10) @(negedge rd_clk);   // rd_en still high on empty
      check_value("rd_dout", rd_dout, expect_dout);   // last word read stays

      // random rates, flags watched by the monitors
      for (seg = 0; seg < 20; seg++) begin
         wr_pct = $urandom % 101;
         rd_pct = $urandom % 101;
         repeat (100) @(posedge rd_clk);
      end
      wr_pct = 0;
      rd_pct = 0;
      repeat (SYNC_STAGES + 3) @(posedge wr_clk);
      repeat (SYNC_STAGES + 3) @(posedge rd_clk);
      @(negedge rd_clk);
      check_value("wr_count", 32'(wr_count), 32'(model_q.size()));
      check_value("rd_count", 32'(rd_count), 32'(model_q.size()));

      $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
fifo_pkg.sv
fifo_rsync.sv
fifo_wr_ptr.sv
fifo_rd_ptr.sv
fifo_dpram.sv
fifo_async.sv
tb_fifo_async.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter project directory"
   exit 1
fi

build_dir=obj_dir
sim_bin=sim_fifo_async

verilator --binary --timing --assert -j 0 \
   --top-module tb_fifo_async \
   -f verilog.f \
   --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$("./$build_dir/$sim_bin")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# pass only on the exact pass line
echo "$output" | grep -qx "SIMULATION PASSED"
if [ $? -ne 0 ]; then
   exit 1
fi
exit 0
